// ==== hdl/colmix_video_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Video side definitions for the colour mixer: channel and palette
// widths, pipeline depth, the RGB bundle and the layer codes
//////////////////////////////////////////////////////////////////////
`default_nettype none

package colmix_video_pkg;

    localparam int COL_W    = 5;   // One colour channel
    localparam int PXL_W    = 8;   // Layer pixel from the layer mixer
    localparam int TMAP_W   = 11;  // Tile-map and video palette address
    localparam int PAL_DW   = 16;  // Palette word
    localparam int PIPE_DLY = 2;   // Pixel strobes from pixel in to colour out

    // Palette word layout
    //   [3:0] red MSBs, [7:4] green MSBs, [11:8] blue MSBs
    //   [14:12] LSBs of red, green, blue
    //   [15] shadow immunity, set means no dimming
    typedef struct packed {
        logic [COL_W-1:0] red;
        logic [COL_W-1:0] green;
        logic [COL_W-1:0] blue;
    } rgb_t;

    // Layer code as driven by the layer mixer
    typedef enum logic [1:0] {
        LYR_TEXT   = 2'd0,
        LYR_FIX    = 2'd1,
        LYR_SPRITE = 2'd2,
        LYR_ROAD   = 2'd3
    } layer_e;

endpackage

`default_nettype wire

// ==== hdl/colmix_cpu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// CPU bus definitions for the palette port: data width and the
// active-low byte strobe type
//////////////////////////////////////////////////////////////////////
`default_nettype none

package colmix_cpu_pkg;

    localparam int CPU_DW = 16;          // CPU data word
    localparam int BE_W   = CPU_DW / 8;  // One strobe per byte

    // Byte strobes, low means write that byte
    // Bit 0 is the low byte, bit 1 the high byte
    typedef logic [BE_W-1:0] be_t;

endpackage

`default_nettype wire

// ==== hdl/colmix_ctl_if.sv ====
//////////////////////////////////////////////////////////////////////
// Delayed video control flags, sync delay to shading stage
// Values are one pixel strobe late, aligned with the palette word
//////////////////////////////////////////////////////////////////////
`default_nettype none

interface colmix_ctl_if;

    logic shadow;    // Dim this pixel unless palette bit 15 set
    logic video_en;  // Low blacks out the colour
    logic lhbl;      // Line blank, active low
    logic lvbl;      // Frame blank, active low

    // Sync delay side
    modport src (
        output shadow,
        output video_en,
        output lhbl,
        output lvbl
    );

    // Shading side
    modport dst (
        input shadow,
        input video_en,
        input lhbl,
        input lvbl
    );

endinterface

`default_nettype wire

// ==== hdl/colmix_pal_ram.sv ====
//////////////////////////////////////////////////////////////////////
// Palette lookup: forms the video palette address from layer code
// and pixel, holds the dual-port palette RAM, serves the CPU port
//////////////////////////////////////////////////////////////////////
`default_nettype none

module colmix_pal_ram #(
    parameter int PAL_AW = 12  // CPU word address width
) (
    input  wire                                  clk,
    input  wire                                  arst_n,
    input  wire                                  pxl_cen,
    // CPU port
    input  wire                                  pal_cs,
    input  wire  [PAL_AW-1:0]                    cpu_addr,
    input  wire  [colmix_cpu_pkg::CPU_DW-1:0]    cpu_dout,
    input  wire  colmix_cpu_pkg::be_t            dswn,
    output logic [colmix_cpu_pkg::CPU_DW-1:0]    cpu_din,
    // Video port
    input  wire  colmix_video_pkg::layer_e       layer_sel,
    input  wire  colmix_video_pkg::layer_e       rc,
    input  wire  [colmix_video_pkg::PXL_W-1:0]   rd_pxl,
    input  wire  [colmix_video_pkg::TMAP_W-1:0]  tmap_addr,
    output logic [colmix_video_pkg::PAL_DW-1:0]  pal_word
);

    import colmix_video_pkg::*;
    import colmix_cpu_pkg::*;

    logic [PAL_DW-1:0] mem [0:2**PAL_AW-1];  // Palette words
    logic [TMAP_W-1:0] rd_mux;                // Address from layer pixel
    logic [TMAP_W-1:0] vid_addr;
    logic [PAL_AW-1:0] vid_full;              // Zero-extended for the RAM

    // Layer pixel to palette address
    always_comb begin
        rd_mux[3:0] = rd_pxl[3:0];  // Colour index within the bank
        case (rc)
            LYR_TEXT,
            LYR_FIX:    rd_mux[5:4] = 2'b11;
            LYR_SPRITE: rd_mux[5:4] = {1'b0, rd_pxl[4]};
            LYR_ROAD:   rd_mux[5:4] = rd_pxl[5:4];
            default:    rd_mux[5:4] = 2'b11;
        endcase
        rd_mux[10:6] = {5{rc[1]}};  // Upper half for sprites and road
    end

    // Selected layer takes the raw tile-map address
    assign vid_addr = (rc == layer_sel) ? tmap_addr : rd_mux;
    assign vid_full = PAL_AW'(vid_addr);

    // CPU byte writes
    always_ff @(posedge clk) begin
        if (pal_cs) begin
            for (int b = 0; b < BE_W; b++) begin
                if (!dswn[b])
                    mem[cpu_addr][b*8 +: 8] <= cpu_dout[b*8 +: 8];
            end
        end
    end

    // CPU read, one cycle after the address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            cpu_din <= '0;
        else
            cpu_din <= mem[cpu_addr];
    end

    // Video read at pixel rate
    // Same-cycle CPU write to this word is not seen until next read
    always_ff @(posedge clk) begin
        if (pxl_cen)
            pal_word <= mem[vid_full];  // Stage 1
    end

    // Strobes must be known whenever the CPU touches the palette
    a_dswn_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        pal_cs |-> !$isunknown(dswn)
    ) else $error("dswn unknown during palette access");

endmodule

`default_nettype wire

// ==== hdl/colmix_sync_delay.sv ====
//////////////////////////////////////////////////////////////////////
// Pixel-rate delay line for shadow, video enable and blanking
// Matches the palette lookup depth so flags meet their palette word
//////////////////////////////////////////////////////////////////////
`default_nettype none

module colmix_sync_delay (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        pxl_cen,
    input  wire        shadow,
    input  wire        video_en,
    input  wire        pre_lhbl,
    input  wire        pre_lvbl,
    colmix_ctl_if.src  ctl
);

    import colmix_video_pkg::*;

    // Shading stage adds the last register of the pipeline
    localparam int STG = PIPE_DLY - 1;

    logic [3:0] stage [STG];  // {shadow, video_en, lhbl, lvbl}

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < STG; i++)
                stage[i] <= 4'b0000;  // No shadow, video off, blanking
        end else if (pxl_cen) begin
            stage[0] <= {shadow, video_en, pre_lhbl, pre_lvbl};
            for (int i = 1; i < STG; i++)
                stage[i] <= stage[i-1];  // Extra depth if ever needed
        end
    end

    assign ctl.shadow   = stage[STG-1][3];
    assign ctl.video_en = stage[STG-1][2];
    assign ctl.lhbl     = stage[STG-1][1];
    assign ctl.lvbl     = stage[STG-1][0];

    // Pixel rate is at most half of clk
    a_cen_gap: assert property (
        @(posedge clk) disable iff (!arst_n)
        pxl_cen |=> !pxl_cen
    ) else $error("pxl_cen high on consecutive cycles");

endmodule

`default_nettype wire

// ==== hdl/colmix_shade.sv ====
//////////////////////////////////////////////////////////////////////
// Shading stage: unpacks the palette word into RGB, dims shadow
// pixels, gates on video enable, registers colour and blanking
//////////////////////////////////////////////////////////////////////
`default_nettype none

module colmix_shade (
    input  wire                                  clk,
    input  wire                                  arst_n,
    input  wire                                  pxl_cen,
    input  wire  [colmix_video_pkg::PAL_DW-1:0]  pal_word,
    colmix_ctl_if.dst                            ctl,
    output colmix_video_pkg::rgb_t               rgb,
    output logic                                 lhbl,
    output logic                                 lvbl
);

    import colmix_video_pkg::*;

    rgb_t raw;    // Straight from the palette word
    rgb_t gated;  // After shadow and video gate

    // Roughly 3/4 brightness
    function automatic logic [COL_W-1:0] dim(input logic [COL_W-1:0] c);
        return c - (c >> 2);
    endfunction

    always_comb begin
        raw.red   = {pal_word[3:0],  pal_word[12]};  // LSB kept in upper bits
        raw.green = {pal_word[7:4],  pal_word[13]};
        raw.blue  = {pal_word[11:8], pal_word[14]};

        gated = raw;
        if (ctl.shadow && !pal_word[15]) begin  // Bit 15 set is immune
            gated.red   = dim(raw.red);
            gated.green = dim(raw.green);
            gated.blue  = dim(raw.blue);
        end
        if (!ctl.video_en)
            gated = '0;  // Screen off
    end

    // Stage 2 of the pixel pipeline
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb  <= '0;
            lhbl <= 1'b0;  // Blanking active
            lvbl <= 1'b0;
        end else if (pxl_cen) begin
            rgb  <= gated;
            lhbl <= ctl.lhbl;
            lvbl <= ctl.lvbl;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/colmix_top.sv ====
//////////////////////////////////////////////////////////////////////
// Colour mixer top level: palette lookup, sync delay and shading
// Two pixel strobes from layer pixel in to RGB out
//////////////////////////////////////////////////////////////////////
`default_nettype none

module colmix_top #(
    parameter int PAL_AW = 12  // 4096 palette words
) (
    input  wire                                  clk,
    input  wire                                  arst_n,
    input  wire                                  pxl_cen,   // Pixel strobe
    input  wire                                  video_en,
    input  wire                                  pre_lhbl,
    input  wire                                  pre_lvbl,
    // CPU interface
    input  wire                                  pal_cs,
    input  wire  [PAL_AW-1:0]                    cpu_addr,
    input  wire  [colmix_cpu_pkg::CPU_DW-1:0]    cpu_dout,
    input  wire  colmix_cpu_pkg::be_t            dswn,
    output logic [colmix_cpu_pkg::CPU_DW-1:0]    cpu_din,
    // From the layer mixer
    input  wire  colmix_video_pkg::layer_e       layer_sel,  // Layer using tmap_addr
    input  wire  [colmix_video_pkg::TMAP_W-1:0]  tmap_addr,
    input  wire  [colmix_video_pkg::PXL_W-1:0]   rd_pxl,
    input  wire  colmix_video_pkg::layer_e       rc,
    input  wire                                  shadow,
    // To the video DAC
    output logic [colmix_video_pkg::COL_W-1:0]   red,
    output logic [colmix_video_pkg::COL_W-1:0]   green,
    output logic [colmix_video_pkg::COL_W-1:0]   blue,
    output logic                                 lhbl,
    output logic                                 lvbl
);

    import colmix_video_pkg::*;

    logic [PAL_DW-1:0] pal_word;  // Stage 1 palette entry
    rgb_t              rgb;

    colmix_ctl_if u_ctl ();       // Stage 1 control flags

    colmix_pal_ram #(
        .PAL_AW (PAL_AW)
    ) u_pal_ram (
        .clk       (clk),
        .arst_n    (arst_n),
        .pxl_cen   (pxl_cen),
        .pal_cs    (pal_cs),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .dswn      (dswn),
        .cpu_din   (cpu_din),
        .layer_sel (layer_sel),
        .rc        (rc),
        .rd_pxl    (rd_pxl),
        .tmap_addr (tmap_addr),
        .pal_word  (pal_word)
    );

    colmix_sync_delay u_sync (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl_cen  (pxl_cen),
        .shadow   (shadow),
        .video_en (video_en),
        .pre_lhbl (pre_lhbl),
        .pre_lvbl (pre_lvbl),
        .ctl      (u_ctl.src)
    );

    colmix_shade u_shade (
        .clk      (clk),
        .arst_n   (arst_n),
        .pxl_cen  (pxl_cen),
        .pal_word (pal_word),
        .ctl      (u_ctl.dst),
        .rgb      (rgb),
        .lhbl     (lhbl),
        .lvbl     (lvbl)
    );

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;

endmodule

`default_nettype wire

// ==== tb/colmix_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the colour mixer: fills the palette over the CPU
// port against a model, then applies a table of layer pixels and
// checks colour and blanking one table entry per pixel strobe
//////////////////////////////////////////////////////////////////////
`default_nettype none

module colmix_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import colmix_video_pkg::*;

    localparam int          PAL_AW   = 12;
    localparam int          N_WORDS  = 2048;  // Video-reachable words
    localparam int          N_ENT    = 16;
    localparam int          RST_CYC  = 8;
    localparam int unsigned SEED     = 32'h2471_2cbc;
    localparam int          CPU_CYC  = RST_CYC + N_WORDS + 6 + 2 * (N_WORDS / 64 + 6);
    localparam int          MAX_CYC  = CPU_CYC + 2 * (N_ENT + 1) + 100;

    typedef struct packed {
        layer_e      rc;
        logic [7:0]  rd;
        logic [10:0] tmap;
        layer_e      sel;
        logic [3:0]  flg;  // {shadow, video_en, pre_lhbl, pre_lvbl}
    } entry_t;

    logic                clk;
    logic                arst_n;
    logic                pxl_cen;
    logic                video_en;
    logic                pre_lhbl;
    logic                pre_lvbl;
    logic                pal_cs;
    logic [PAL_AW-1:0]   cpu_addr;
    logic [15:0]         cpu_dout;
    logic [1:0]          dswn;
    logic [15:0]         cpu_din;
    layer_e              layer_sel;
    logic [TMAP_W-1:0]   tmap_addr;
    logic [PXL_W-1:0]    rd_pxl;
    layer_e              rc;
    logic                shadow;
    logic [COL_W-1:0]    red;
    logic [COL_W-1:0]    green;
    logic [COL_W-1:0]    blue;
    logic                lhbl;
    logic                lvbl;

    logic [15:0] model [N_WORDS];  // Everything written so far
    int          n_checks = 0;
    int          n_err    = 0;
    int          cyc_cnt  = 0;

    // Both layer_sel matches and misses for every layer code
    entry_t tbl [N_ENT] = '{
        '{LYR_TEXT,   8'h3a, 11'h100, LYR_TEXT,   4'b1111},  // Shadow, bit 15 clear
        '{LYR_TEXT,   8'h3b, 11'h101, LYR_TEXT,   4'b1111},  // Shadow, bit 15 set
        '{LYR_TEXT,   8'h5c, 11'h155, LYR_FIX,    4'b0111},
        '{LYR_FIX,    8'h07, 11'h2aa, LYR_FIX,    4'b0110},
        '{LYR_FIX,    8'hf9, 11'h0f0, LYR_ROAD,   4'b1111},
        '{LYR_SPRITE, 8'h1e, 11'h333, LYR_TEXT,   4'b0101},
        '{LYR_SPRITE, 8'h2e, 11'h444, LYR_SPRITE, 4'b0111},
        '{LYR_SPRITE, 8'hef, 11'h555, LYR_ROAD,   4'b1111},
        '{LYR_ROAD,   8'h25, 11'h666, LYR_FIX,    4'b0111},
        '{LYR_ROAD,   8'hd3, 11'h777, LYR_ROAD,   4'b0111},
        '{LYR_ROAD,   8'h3f, 11'h010, LYR_TEXT,   4'b0011},  // Video off
        '{LYR_TEXT,   8'h00, 11'h200, LYR_TEXT,   4'b0100},
        '{LYR_FIX,    8'h11, 11'h201, LYR_FIX,    4'b1010},  // Shadow with video off
        '{LYR_SPRITE, 8'h04, 11'h202, LYR_SPRITE, 4'b0111},
        '{LYR_ROAD,   8'h10, 11'h203, LYR_ROAD,   4'b1101},
        '{LYR_TEXT,   8'hff, 11'h7ff, LYR_TEXT,   4'b1111}
    };

    colmix_top #(
        .PAL_AW (PAL_AW)
    ) u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .pxl_cen   (pxl_cen),
        .video_en  (video_en),
        .pre_lhbl  (pre_lhbl),
        .pre_lvbl  (pre_lvbl),
        .pal_cs    (pal_cs),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .dswn      (dswn),
        .cpu_din   (cpu_din),
        .layer_sel (layer_sel),
        .tmap_addr (tmap_addr),
        .rd_pxl    (rd_pxl),
        .rc        (rc),
        .shadow    (shadow),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl      (lhbl),
        .lvbl      (lvbl)
    );

    always #50 clk = ~clk;  // 100 ns period

    // Watchdog sized from the test length
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= MAX_CYC) begin
            $display("Timeout after %0d cycles, the test did not reach its end", cyc_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Palette address from layer code and pixel
    function automatic logic [10:0] exp_addr(input entry_t e);
        logic [10:0] a;
        if (e.rc == e.sel)
            return e.tmap;  // Raw tile-map address
        a[3:0] = e.rd[3:0];
        case (e.rc)
            LYR_SPRITE: a[5:4] = {1'b0, e.rd[4]};
            LYR_ROAD:   a[5:4] = e.rd[5:4];
            default:    a[5:4] = 2'b11;  // Text and fix
        endcase
        a[10:6] = {5{e.rc[1]}};
        return a;
    endfunction

    // Unpacked, dimmed and gated colour as {r, g, b}
    function automatic logic [14:0] exp_rgb(input logic [15:0] w, input logic [3:0] flg);
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = {w[3:0], w[12]};
        g = {w[7:4], w[13]};
        b = {w[11:8], w[14]};
        if (flg[3] && !w[15]) begin
            r = r - (r >> 2);
            g = g - (g >> 2);
            b = b - (b >> 2);
        end
        if (!flg[2])
            return '0;  // Screen off
        return {r, g, b};
    endfunction

    task automatic cpu_write(input logic [10:0] a, input logic [15:0] d, input logic [1:0] be);
        @(posedge clk);
        pal_cs   <= 1'b1;
        cpu_addr <= PAL_AW'(a);
        cpu_dout <= d;
        dswn     <= be;
        if (!be[0])
            model[a][7:0] = d[7:0];
        if (!be[1])
            model[a][15:8] = d[15:8];
    endtask

    task automatic cpu_read_check(input logic [10:0] a);
        @(posedge clk);
        pal_cs   <= 1'b0;  // Also lets a pending write land
        cpu_addr <= PAL_AW'(a);
        @(posedge clk);
        @(negedge clk);
        check("cpu_din", cpu_din, model[a]);
    endtask

    task automatic drive_entry(input entry_t e);
        rc        <= e.rc;
        rd_pxl    <= e.rd;
        tmap_addr <= e.tmap;
        layer_sel <= e.sel;
        {shadow, video_en, pre_lhbl, pre_lvbl} <= e.flg;
    endtask

    task automatic check_entry(input entry_t e);
        logic [14:0] c;
        c = exp_rgb(model[exp_addr(e)], e.flg);
        check("red",   16'(red),   16'(c[14:10]));
        check("green", 16'(green), 16'(c[9:5]));
        check("blue",  16'(blue),  16'(c[4:0]));
        check("lhbl",  16'(lhbl),  16'(e.flg[1]));
        check("lvbl",  16'(lvbl),  16'(e.flg[0]));
    endtask

    initial begin
        void'($urandom(SEED));
        clk       = 1'b0;
        arst_n    = 1'b0;
        pxl_cen   = 1'b0;
        video_en  = 1'b0;
        pre_lhbl  = 1'b0;
        pre_lvbl  = 1'b0;
        pal_cs    = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        dswn      = 2'b11;
        layer_sel = LYR_TEXT;
        tmap_addr = '0;
        rd_pxl    = '0;
        rc        = LYR_TEXT;
        shadow    = 1'b0;

        repeat (RST_CYC) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check("red", 16'(red), 16'h0);  // Reset state
        check("green", 16'(green), 16'h0);
        check("blue", 16'(blue), 16'h0);
        check("lhbl", 16'(lhbl), 16'h0);
        check("lvbl", 16'(lvbl), 16'h0);
        check("cpu_din", cpu_din, 16'h0);

        for (int a = 0; a < N_WORDS; a++)
            cpu_write(11'(a), 16'($urandom), 2'b00);
        cpu_write(11'h100, 16'h7bde, 2'b00);
        cpu_write(11'h101, 16'hfbde, 2'b00);
        cpu_write(11'h200, 16'h1234, 2'b00);
        cpu_write(11'h200, 16'habcd, 2'b10);  // Low byte only
        cpu_write(11'h201, 16'hbeef, 2'b01);  // High byte only
        cpu_write(11'h202, 16'h5555, 2'b11);  // No byte
        for (int a = 0; a < N_WORDS; a += 64)
            cpu_read_check(11'(a));
        for (int a = 'h200; a < 'h204; a++)
            cpu_read_check(11'(a));
        cpu_read_check(11'h100);
        cpu_read_check(11'h101);

        // One entry per strobe, result visible after the following strobe
        for (int i = 0; i <= N_ENT; i++) begin
            @(posedge clk);
            if (i < N_ENT)
                drive_entry(tbl[i]);
            pxl_cen <= 1'b1;
            @(posedge clk);
            pxl_cen <= 1'b0;
            @(negedge clk);
            if (i >= 1)
                check_entry(tbl[i-1]);
        end

        $display("Checks: %0d, errors: %0d", n_checks, n_err);
        if (n_err == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/colmix_video_pkg.sv
hdl/colmix_cpu_pkg.sv
hdl/colmix_ctl_if.sv
hdl/colmix_pal_ram.sv
hdl/colmix_sync_delay.sv
hdl/colmix_shade.sv
hdl/colmix_top.sv
tb/colmix_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the colour mixer testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=colmix_sim
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module colmix_tb -f project.f \
        --Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
